/* pea_token_pkg.sv */
// token formats and FIFO sizing; arithmetic is unsigned and FIFO depth must stay a power of two
package pea_token_pkg;

    localparam int WORD_SIZE  = 16;                // data and command token width
    localparam int FIFO_DEPTH = 16;                // entries per input FIFO
    localparam int ADDR_W     = 4;                 // log2 of FIFO_DEPTH
    localparam int POP_W      = 5;                 // population needs one extra bit for full

    // command token as written by the host
    typedef struct packed {
        logic [7:0] opcode;                        // operation select
        logic [2:0] arg1;                          // data tokens to consume
        logic [4:0] arg2;                          // constant b
    } cmd_token_t;

    typedef enum logic [7:0] {
        OP_SUM         = 8'h01,                    // plain sum
        OP_MAX         = 8'h02,                    // unsigned max, 0 if nothing read
        OP_SCALE_SUM   = 8'h03,                    // sum of token * b
        OP_COUNT_ABOVE = 8'h04                     // count of tokens > b
    } pea_op_e;

    typedef logic [31:0] result_t;                 // sums wrap mod 2^32

    typedef struct packed {
        logic [7:0]  opcode;                       // opcode of the firing
        logic [2:0]  consumed;                     // data tokens actually read
        logic        bad_op;                       // opcode not recognised
        logic        short_data;                   // fewer data tokens than arg1
        logic        reused;                       // stored command was run again
        logic [17:0] spare;                        // always zero
    } status_token_t;

endpackage

/* pea_ctrl_pkg.sv */
// control encodings of the actor; next_instr value 11 behaves as fetch
package pea_ctrl_pkg;

    import pea_token_pkg::*;

    typedef enum logic [1:0] {
        INV_IDLE,                                  // waiting for invoke
        INV_START,                                 // one cycle start pulse
        INV_WAIT                                   // firing in progress
    } invoke_state_e;

    typedef enum logic [2:0] {
        F_IDLE, F_CHECK, F_READ_CMD, F_LATCH_CMD,
        F_READ_DATA, F_DRAIN, F_WRITE, F_DONE
    } fire_state_e;

    typedef enum logic [1:0] {
        NEXT_FETCH = 2'b00,                        // pop a new command
        NEXT_REUSE = 2'b01,                        // run the stored command again
        NEXT_CLEAR = 2'b10                         // drop the stored command
    } next_mode_e;

    // FSM to accumulator control bundle
    typedef struct packed {
        logic       clear;                         // restart the fold
        logic       take;                          // data token valid this cycle
        logic       finish;                        // capture result and status
        cmd_token_t cmd;                           // command in use
        logic       bad_op;
        logic       short_data;
        logic       reused;
    } acc_ctl_t;

endpackage

/* pea_token_fifo.sv */
// single clock FIFO with registered read; writes when full and reads when empty are dropped
`timescale 1ns/1ns
module pea_token_fifo
    import pea_token_pkg::*;
#(
    parameter type payload_t = logic [WORD_SIZE-1:0]
)
(
    input  logic              clk,
    input  logic              rst_instr,
    input  logic              wr,
    input  payload_t          wr_data,
    input  logic              rd,
    output payload_t          rd_data,
    output logic [POP_W-1:0]  pop,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [ADDR_W-1:0] rd_addr
);

    payload_t mem [FIFO_DEPTH];                    // token storage
    logic     full;
    logic     empty;
    logic     wr_ok;
    logic     rd_ok;

    assign full  = (pop == POP_W'(FIFO_DEPTH));
    assign empty = (pop == '0);
    assign wr_ok = wr && !full;
    assign rd_ok = rd && !empty;

    always_ff @(posedge clk)
    begin
        if (wr_ok)
            mem[wr_addr] <= wr_data;
        if (rd_ok)
            rd_data <= mem[rd_addr];               // head shows up one cycle after rd
    end

    always_ff @(posedge clk or negedge rst_instr)
    begin
        if (!rst_instr)
        begin
            wr_addr <= '0;
            rd_addr <= '0;
            pop     <= '0;
        end
        else
        begin
            if (wr_ok)
                wr_addr <= wr_addr + 1'b1;         // wraps at depth
            if (rd_ok)
                rd_addr <= rd_addr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   pop <= pop + 1'b1;
                2'b01:   pop <= pop - 1'b1;
                default: pop <= pop;               // both or neither
            endcase
        end
    end

    // host must watch the population before writing
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_instr) !(wr && full))
        else $error("token fifo write while full");
    // FSM checks population before any read
    a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_instr) !(rd && empty))
        else $error("token fifo read while empty");

endmodule

/* pea_token_counter.sv */
// arg1 read counter; a load restarts the consumed count in the same cycle
`timescale 1ns/1ns
module pea_token_counter
(
    input  logic       clk,
    input  logic       rst_instr,
    input  logic       load,
    input  logic [2:0] load_count,
    input  logic       issue,
    input  logic       take,
    output logic       last_issue,
    output logic [2:0] consumed
);

    logic [2:0] remain;                            // reads still to issue
    logic [2:0] taken;                             // tokens folded since load

    always_ff @(posedge clk or negedge rst_instr)
    begin
        if (!rst_instr)
        begin
            remain <= 3'd0;
            taken  <= 3'd0;
        end
        else
        begin
            if (load)
                remain <= load_count;
            else if (issue)
                remain <= remain - 3'd1;
            if (load)
                taken <= 3'd0;
            else if (take)
                taken <= taken + 3'd1;
        end
    end

    assign last_issue = (remain == 3'd1);          // FSM leaves the read state after this
    assign consumed   = load ? 3'd0 : taken;       // no stale count when finish meets load

    // FSM must stop issuing once the count runs out
    a_no_issue_at_zero: assert property (@(posedge clk) disable iff (!rst_instr)
        issue |-> remain != 3'd0)
        else $error("data read issued with no reads left");

endmodule

/* pea_accumulator.sv */
// unsigned fold datapath; result and status hold their value until the next finish
`timescale 1ns/1ns
module pea_accumulator
    import pea_token_pkg::*, pea_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_instr,
    input  acc_ctl_t             ctl,
    input  logic [WORD_SIZE-1:0] token,
    input  logic [2:0]           consumed,
    output result_t              result,
    output status_token_t        status
);

    result_t       acc;                            // running fold
    result_t       acc_base;                       // fold before this cycle's token
    result_t       acc_next;                       // fold including this cycle's token
    result_t       b;                              // arg2 widened
    status_token_t status_d;

    assign b        = result_t'(ctl.cmd.arg2);
    assign acc_base = ctl.clear ? '0 : acc;        // clear may meet finish when arg1 is 0

    always_comb
    begin
        acc_next = acc_base;
        case (ctl.cmd.opcode)
            OP_SUM:
                acc_next = acc_base + result_t'(token);
            OP_MAX:
                if (result_t'(token) > acc_base)
                    acc_next = result_t'(token);
            OP_SCALE_SUM:
                acc_next = acc_base + result_t'(token) * b;
            OP_COUNT_ABOVE:
                if (token > WORD_SIZE'(ctl.cmd.arg2))
                    acc_next = acc_base + 32'd1;
            default:
                acc_next = acc_base;               // bad opcodes never take data
        endcase
    end

    always_ff @(posedge clk)
    begin
        acc <= ctl.take ? acc_next : acc_base;
    end

    always_comb
    begin
        status_d            = '0;                  // spare stays zero
        status_d.opcode     = ctl.cmd.opcode;
        status_d.consumed   = consumed + 3'(ctl.take);  // last token lands with finish
        status_d.bad_op     = ctl.bad_op;
        status_d.short_data = ctl.short_data;
        status_d.reused     = ctl.reused;
    end

    always_ff @(posedge clk or negedge rst_instr)
    begin
        if (!rst_instr)
        begin
            result <= '0;
            status <= '0;
        end
        else if (ctl.finish)                       // F_WRITE follows next cycle
        begin
            if (ctl.bad_op || ctl.short_data)
                result <= '0;
            else
                result <= ctl.take ? acc_next : acc_base;
            status <= status_d;
        end
    end

endmodule

/* pea_firing_fsm.sv */
// one firing per start; missing tokens are reported in the status and never waited for
`timescale 1ns/1ns
module pea_firing_fsm
    import pea_token_pkg::*, pea_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_instr,
    input  logic             start,
    input  next_mode_e       next_instr,
    input  logic [POP_W-1:0] command_pop,
    input  logic [POP_W-1:0] data_pop,
    input  cmd_token_t       command_token,
    input  logic             last_issue,
    output logic             rd_in_command,
    output logic             rd_in_data,
    output logic             counter_load,
    output acc_ctl_t         acc_ctl,
    output logic [7:0]       instr,
    output logic [4:0]       arg2,
    output logic             wr_out,
    output logic             done
);

    fire_state_e      state, state_d;
    cmd_token_t       cmd_q, cmd_d;                // stored instruction
    logic [POP_W-1:0] data_pop_q;                  // data population seen in F_CHECK
    logic [POP_W-1:0] pop_now;
    logic             bad_q, bad_d;
    logic             short_q, short_d;
    logic             reused_q, reused_d;
    logic             take_q;                      // data read one cycle ago
    logic             decide;                      // command known, pick the data path

    assign pop_now = (state == F_CHECK) ? data_pop : data_pop_q;

    always_comb
    begin
        state_d  = state;
        cmd_d    = cmd_q;
        bad_d    = bad_q;
        short_d  = short_q;
        reused_d = reused_q;
        decide   = 1'b0;
        case (state)
            F_IDLE:
                if (start)
                begin
                    state_d  = F_CHECK;
                    bad_d    = 1'b0;
                    short_d  = 1'b0;
                    reused_d = 1'b0;
                end
            F_CHECK:
                if (next_instr == NEXT_CLEAR)
                begin
                    cmd_d   = '0;                  // nothing read, nothing written
                    state_d = F_DONE;
                end
                else if (next_instr == NEXT_REUSE && cmd_q.opcode != 8'd0)
                begin
                    reused_d = 1'b1;
                    decide   = 1'b1;
                end
                else if (command_pop == '0)
                    state_d = F_DONE;              // empty command FIFO ends quietly
                else
                    state_d = F_READ_CMD;
            F_READ_CMD:  state_d = F_LATCH_CMD;
            F_LATCH_CMD:
            begin
                cmd_d  = command_token;            // fifo head valid now
                decide = 1'b1;
            end
            F_READ_DATA:
                if (last_issue)
                    state_d = F_DRAIN;
            F_DRAIN:     state_d = F_WRITE;        // last token arrives here
            F_WRITE:     state_d = F_DONE;
            default:     state_d = F_IDLE;         // F_DONE
        endcase
        if (decide)
        begin
            bad_d   = !(cmd_d.opcode inside {OP_SUM, OP_MAX, OP_SCALE_SUM, OP_COUNT_ABOVE});
            short_d = !bad_d && (pop_now < POP_W'(cmd_d.arg1));
            if (bad_d || short_d || cmd_d.arg1 == 3'd0)
                state_d = F_WRITE;                 // no data to read
            else
                state_d = F_READ_DATA;
        end
    end

    always_ff @(posedge clk or negedge rst_instr)
    begin
        if (!rst_instr)
        begin
            state      <= F_IDLE;
            cmd_q      <= '0;
            data_pop_q <= '0;
            bad_q      <= 1'b0;
            short_q    <= 1'b0;
            reused_q   <= 1'b0;
            take_q     <= 1'b0;
        end
        else
        begin
            state    <= state_d;
            cmd_q    <= cmd_d;
            bad_q    <= bad_d;
            short_q  <= short_d;
            reused_q <= reused_d;
            take_q   <= rd_in_data;
            if (state == F_CHECK)
                data_pop_q <= data_pop;
        end
    end

    assign rd_in_command = (state == F_READ_CMD);
    assign rd_in_data    = (state == F_READ_DATA);
    assign wr_out        = (state == F_WRITE);
    assign done          = (state == F_DONE);
    assign counter_load  = decide;                 // arg1 loads as the command is known
    assign instr         = cmd_q.opcode;
    assign arg2          = cmd_q.arg2;

    assign acc_ctl.clear      = (state == F_CHECK);
    assign acc_ctl.take       = take_q;
    assign acc_ctl.finish     = (state_d == F_WRITE);  // one cycle ahead of wr_out
    assign acc_ctl.cmd        = cmd_d;
    assign acc_ctl.bad_op     = bad_d;
    assign acc_ctl.short_data = short_d;
    assign acc_ctl.reused     = reused_d;

    // sequencer only starts from idle, so the two never overlap
    a_done_not_start: assert property (@(posedge clk) disable iff (!rst_instr)
        !(done && start))
        else $error("done raised during start");
    // data reads only with tokens present
    a_rd_data_avail: assert property (@(posedge clk) disable iff (!rst_instr)
        rd_in_data |-> data_pop != '0)
        else $error("data read with the data FIFO empty");

endmodule

/* pea_actor.sv */
// processing element actor; no output back-pressure and invoke is ignored while a firing runs
`timescale 1ns/1ns
module pea_actor
    import pea_token_pkg::*, pea_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_instr,
    input  logic                 command_wr,
    input  cmd_token_t           command_in,
    input  logic                 data_wr,
    input  logic [WORD_SIZE-1:0] data_in,
    input  logic                 invoke,
    input  logic [1:0]           next_instr,
    output logic                 rd_in_command,
    output logic                 rd_in_data,
    output logic                 FC,
    output logic                 wr_out,
    output result_t              data_out_result,
    output status_token_t        data_out_status,
    output logic [7:0]           instr,
    output logic [4:0]           arg2,
    output logic [ADDR_W-1:0]    wr_addr_command,
    output logic [ADDR_W-1:0]    rd_addr_command,
    output logic [ADDR_W-1:0]    wr_addr_data,
    output logic [ADDR_W-1:0]    rd_addr_data
);

    invoke_state_e        inv_state, inv_state_d;
    logic                 start;                   // one cycle kick to the FSM
    logic                 done;
    logic                 counter_load;
    logic                 last_issue;
    logic [2:0]           consumed;
    logic [POP_W-1:0]     command_pop;
    logic [POP_W-1:0]     data_pop;
    cmd_token_t           command_token;
    logic [WORD_SIZE-1:0] data_token;
    acc_ctl_t             acc_ctl;

    always_comb
    begin
        case (inv_state)
            INV_IDLE:  inv_state_d = invoke ? INV_START : INV_IDLE;
            INV_START: inv_state_d = INV_WAIT;
            INV_WAIT:  inv_state_d = done ? INV_IDLE : INV_WAIT;
            default:   inv_state_d = INV_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_instr)
    begin
        if (!rst_instr)
            inv_state <= INV_IDLE;
        else
            inv_state <= inv_state_d;
    end

    assign start = (inv_state == INV_START);
    assign FC    = done;                           // firing complete

    pea_token_fifo #(.payload_t(cmd_token_t)) u_cmd_fifo (
        .clk       (clk),
        .rst_instr (rst_instr),
        .wr        (command_wr),
        .wr_data   (command_in),
        .rd        (rd_in_command),
        .rd_data   (command_token),
        .pop       (command_pop),
        .wr_addr   (wr_addr_command),
        .rd_addr   (rd_addr_command)
    );

    pea_token_fifo #(.payload_t(logic [WORD_SIZE-1:0])) u_data_fifo (
        .clk       (clk),
        .rst_instr (rst_instr),
        .wr        (data_wr),
        .wr_data   (data_in),
        .rd        (rd_in_data),
        .rd_data   (data_token),
        .pop       (data_pop),
        .wr_addr   (wr_addr_data),
        .rd_addr   (rd_addr_data)
    );

    pea_firing_fsm u_fsm (
        .clk           (clk),
        .rst_instr     (rst_instr),
        .start         (start),
        .next_instr    (next_mode_e'(next_instr)),
        .command_pop   (command_pop),
        .data_pop      (data_pop),
        .command_token (command_token),
        .last_issue    (last_issue),
        .rd_in_command (rd_in_command),
        .rd_in_data    (rd_in_data),
        .counter_load  (counter_load),
        .acc_ctl       (acc_ctl),
        .instr         (instr),
        .arg2          (arg2),
        .wr_out        (wr_out),
        .done          (done)
    );

    pea_token_counter u_counter (
        .clk        (clk),
        .rst_instr  (rst_instr),
        .load       (counter_load),
        .load_count (acc_ctl.cmd.arg1),            // command in use, fetched or stored
        .issue      (rd_in_data),
        .take       (acc_ctl.take),
        .last_issue (last_issue),
        .consumed   (consumed)
    );

    pea_accumulator u_acc (
        .clk       (clk),
        .rst_instr (rst_instr),
        .ctl       (acc_ctl),
        .token     (data_token),
        .consumed  (consumed),
        .result    (data_out_result),
        .status    (data_out_status)
    );

endmodule

/* pea_tb.sv */
// directed testbench for pea_actor; queue model of both FIFOs, data FIFO kept below 16 tokens
`timescale 1ns/1ns
module pea_tb
    import pea_token_pkg::*, pea_ctrl_pkg::*;
;

    localparam int N_FIRES         = 19;           // firings issued by all tests
    localparam int CYCLES_PER_FIRE = 200;
    localparam int MARGIN          = 400;          // reset, pushes and idle gaps

    logic                 clk = 1'b0;
    logic                 rst_instr;
    logic                 command_wr;
    cmd_token_t           command_in;
    logic                 data_wr;
    logic [WORD_SIZE-1:0] data_in;
    logic                 invoke;
    logic [1:0]           next_instr;
    logic                 rd_in_command;
    logic                 rd_in_data;
    logic                 FC;
    logic                 wr_out;
    result_t              data_out_result;
    status_token_t        data_out_status;
    logic [7:0]           instr;
    logic [4:0]           arg2;
    logic [ADDR_W-1:0]    wr_addr_command;
    logic [ADDR_W-1:0]    rd_addr_command;
    logic [ADDR_W-1:0]    wr_addr_data;
    logic [ADDR_W-1:0]    rd_addr_data;

    cmd_token_t           cmd_model[$];            // expected command FIFO contents
    logic [WORD_SIZE-1:0] data_model[$];           // expected data FIFO contents
    cmd_token_t           stored;                  // expected stored instruction
    logic [ADDR_W-1:0]    cmd_wr_ptr, cmd_rd_ptr;
    logic [ADDR_W-1:0]    data_wr_ptr, data_rd_ptr;
    logic                 exp_wr;
    result_t              exp_result;
    status_token_t        exp_status;
    logic [31:0]          lcg_state;

    always #2 clk = ~clk;                          // 4 ns period

    pea_actor u_dut (
        .clk             (clk),
        .rst_instr       (rst_instr),
        .command_wr      (command_wr),
        .command_in      (command_in),
        .data_wr         (data_wr),
        .data_in         (data_in),
        .invoke          (invoke),
        .next_instr      (next_instr),
        .rd_in_command   (rd_in_command),
        .rd_in_data      (rd_in_data),
        .FC              (FC),
        .wr_out          (wr_out),
        .data_out_result (data_out_result),
        .data_out_status (data_out_status),
        .instr           (instr),
        .arg2            (arg2),
        .wr_addr_command (wr_addr_command),
        .rd_addr_command (rd_addr_command),
        .wr_addr_data    (wr_addr_data),
        .rd_addr_data    (rd_addr_data)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cmd_token_t make_cmd(input logic [7:0] op, input logic [2:0] a1,
                                            input logic [4:0] a2);
        return {op, a1, a2};
    endfunction

    // one fold step written from the opcode rules
    function automatic result_t fold_token(input result_t acc, input logic [7:0] op,
                                           input logic [4:0] b, input logic [15:0] tok);
        result_t t;
        t = {16'd0, tok};
        case (op)
            OP_SUM:       return acc + t;
            OP_MAX:       return (t > acc) ? t : acc;
            OP_SCALE_SUM: return acc + t * {27'd0, b};
            default:      return (tok > {11'd0, b}) ? acc + 32'd1 : acc;   // count above
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic push_command(input cmd_token_t c);
        @(posedge clk);
        command_wr <= 1'b1;
        command_in <= c;
        @(posedge clk);
        command_wr <= 1'b0;
        cmd_model.push_back(c);
        cmd_wr_ptr = cmd_wr_ptr + 4'd1;
    endtask

    task automatic push_data(input logic [WORD_SIZE-1:0] d);
        @(posedge clk);
        data_wr <= 1'b1;
        data_in <= d;
        @(posedge clk);
        data_wr <= 1'b0;
        data_model.push_back(d);
        data_wr_ptr = data_wr_ptr + 4'd1;
    endtask

    task automatic push_random_data(input int n);
        logic [31:0] r;
        int i;
        for (i = 0; i < n; i++)
        begin
            r = next_rand();
            push_data(r[23] ? r[31:16] : {11'd0, r[4:0]});   // mix small and large values
        end
    endtask

    // predicts one firing from the model queues and the stored command
    task automatic predict_firing(input logic [1:0] mode);
        cmd_token_t           c;
        logic                 bad;
        logic                 is_short;
        logic                 reused;
        logic [2:0]           n;
        logic [WORD_SIZE-1:0] tok;
        result_t              acc;
        int                   i;
        exp_wr = 1'b0;
        reused = 1'b0;
        if (mode == NEXT_CLEAR)
        begin
            stored = '0;
            return;
        end
        if (mode == NEXT_REUSE && stored.opcode != 8'd0)
            reused = 1'b1;
        else if (cmd_model.size() == 0)
            return;                                // quiet end, no output token
        else
        begin
            stored = cmd_model.pop_front();
            cmd_rd_ptr = cmd_rd_ptr + 4'd1;
        end
        c = stored;
        bad = !(c.opcode inside {OP_SUM, OP_MAX, OP_SCALE_SUM, OP_COUNT_ABOVE});
        is_short = !bad && (data_model.size() < int'(c.arg1));
        acc = '0;
        n = 3'd0;
        if (!bad && !is_short)
        begin
            for (i = 0; i < int'(c.arg1); i++)
            begin
                tok = data_model.pop_front();
                data_rd_ptr = data_rd_ptr + 4'd1;
                acc = fold_token(acc, c.opcode, c.arg2, tok);
                n = n + 3'd1;
            end
        end
        exp_wr                = 1'b1;
        exp_result            = (bad || is_short) ? '0 : acc;
        exp_status            = '0;
        exp_status.opcode     = c.opcode;
        exp_status.consumed   = n;
        exp_status.bad_op     = bad;
        exp_status.short_data = is_short;
        exp_status.reused     = reused;
    endtask

    // invoke once, optionally pulse a stray invoke mid firing, then compare everything
    task automatic fire(input logic [1:0] mode, input logic stray);
        int            cycles;
        int            wr_count;
        int            fc_count;
        logic          prev_wr;
        result_t       got_result;
        status_token_t got_status;
        predict_firing(mode);
        cycles     = 0;
        wr_count   = 0;
        fc_count   = 0;
        prev_wr    = 1'b0;
        got_result = '0;
        got_status = '0;
        @(posedge clk);
        invoke     <= 1'b1;
        next_instr <= mode;
        while (fc_count == 0)                      // watchdog bounds this loop
        begin
            @(posedge clk);
            invoke <= stray && (cycles == 3);
            @(negedge clk);                        // outputs settled mid cycle
            cycles++;
            if (FC)
            begin
                fc_count++;
                check("wr_out one cycle before FC", {31'd0, prev_wr}, {31'd0, exp_wr});
            end
            if (wr_out)
            begin
                wr_count++;
                got_result = data_out_result;
                got_status = data_out_status;
            end
            prev_wr = wr_out;
        end
        repeat (8)                                 // nothing more may follow FC
        begin
            @(posedge clk);
            invoke <= 1'b0;
            @(negedge clk);
            if (wr_out)
                wr_count++;
            if (FC)
                fc_count++;
        end
        check("wr_out pulse count", 32'(wr_count), {31'd0, exp_wr});
        check("FC pulse count", 32'(fc_count), 32'd1);
        if (exp_wr)
        begin
            check("data_out_result", got_result, exp_result);
            check("data_out_status", got_status, exp_status);
        end
        check("instr", {24'd0, instr}, {24'd0, stored.opcode});
        check("arg2", {27'd0, arg2}, {27'd0, stored.arg2});
        check("wr_addr_command", {28'd0, wr_addr_command}, {28'd0, cmd_wr_ptr});
        check("rd_addr_command", {28'd0, rd_addr_command}, {28'd0, cmd_rd_ptr});
        check("wr_addr_data", {28'd0, wr_addr_data}, {28'd0, data_wr_ptr});
        check("rd_addr_data", {28'd0, rd_addr_data}, {28'd0, data_rd_ptr});
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check("rd_in_command", {31'd0, rd_in_command}, 32'd0);
        check("rd_in_data", {31'd0, rd_in_data}, 32'd0);
        check("wr_out", {31'd0, wr_out}, 32'd0);
        check("FC", {31'd0, FC}, 32'd0);
        check("instr", {24'd0, instr}, 32'd0);
    endtask

    task automatic test_opcodes();
        logic [31:0] r;
        cmd_token_t  c;
        int          op;
        int          k;
        for (op = 1; op <= 4; op++)
        begin
            for (k = 0; k < 2; k++)
            begin
                r = next_rand();
                c.opcode = 8'(op);
                c.arg1   = (k == 0) ? (r[10:8] | 3'd1) : r[10:8];   // second round may be 0
                c.arg2   = r[20:16];
                push_command(c);
                push_random_data(int'(c.arg1));
                fire(NEXT_FETCH, 1'b0);
            end
        end
    endtask

    task automatic test_reuse_clear();
        push_command(make_cmd(OP_SCALE_SUM, 3'd3, 5'd7));
        push_random_data(3);
        fire(NEXT_FETCH, 1'b0);
        push_random_data(3);
        fire(NEXT_REUSE, 1'b0);                    // no command read, reused flag
        fire(NEXT_CLEAR, 1'b0);
        push_command(make_cmd(OP_SUM, 3'd2, 5'd1));
        push_random_data(2);
        fire(NEXT_REUSE, 1'b0);                    // nothing stored so it fetches
        push_command(make_cmd(OP_MAX, 3'd2, 5'd0));
        push_random_data(2);
        fire(2'b11, 1'b0);                         // spare encoding acts as fetch
    endtask

    task automatic test_bad_opcode();
        logic [ADDR_W-1:0] rd_before;
        push_command(make_cmd(8'h7f, 3'd2, 5'd3));
        push_random_data(2);
        rd_before = data_rd_ptr;
        fire(NEXT_FETCH, 1'b0);
        check("rd_addr_data after bad opcode", {28'd0, rd_addr_data}, {28'd0, rd_before});
        push_command(make_cmd(OP_SUM, 3'd2, 5'd0));   // drains the two kept tokens
        fire(NEXT_FETCH, 1'b0);
    endtask

    task automatic test_short_data();
        push_command(make_cmd(OP_MAX, 3'd5, 5'd0));
        push_random_data(3);
        fire(NEXT_FETCH, 1'b0);
        push_command(make_cmd(OP_SUM, 3'd3, 5'd0));   // uses the data left behind
        fire(NEXT_FETCH, 1'b0);
    endtask

    task automatic test_empty_command();
        fire(NEXT_FETCH, 1'b0);                    // every pushed command is used up by now
    endtask

    task automatic test_stray_invoke();
        push_command(make_cmd(OP_COUNT_ABOVE, 3'd4, 5'd9));
        push_random_data(4);
        fire(NEXT_FETCH, 1'b1);
    endtask

    initial
    begin
        repeat (N_FIRES * CYCLES_PER_FIRE + MARGIN) @(posedge clk);
        $display("timeout: firings did not complete within %0d cycles",
                 N_FIRES * CYCLES_PER_FIRE + MARGIN);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst_instr   = 1'b0;
        command_wr  = 1'b0;
        command_in  = '0;
        data_wr     = 1'b0;
        data_in     = '0;
        invoke      = 1'b0;
        next_instr  = 2'b00;
        stored      = '0;
        cmd_wr_ptr  = '0;
        cmd_rd_ptr  = '0;
        data_wr_ptr = '0;
        data_rd_ptr = '0;
        exp_wr      = 1'b0;
        exp_result  = '0;
        exp_status  = '0;
        lcg_state   = 32'h1dae_0651;
        repeat (16) @(posedge clk);
        rst_instr <= 1'b1;
        test_reset_state();
        test_opcodes();
        test_reuse_clear();
        test_bad_opcode();
        test_short_data();
        test_empty_command();
        test_stray_invoke();
        $display("All checks passed");
        $finish;
    end

endmodule

/* build.f */
pea_token_pkg.sv
pea_ctrl_pkg.sv
pea_token_fifo.sv
pea_token_counter.sv
pea_accumulator.sv
pea_firing_fsm.sv
pea_actor.sv
pea_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the actor testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pea_tb -f build.f -o pea_sim \
    > sim.log 2>&1 && ./obj_dir/pea_sim >> sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
exit 0
